/* hdl/fetch_pkg.sv */
// shared widths, encodings and structs of the fetch unit; compile ahead of every RTL and bench file
package fetch_pkg;

   // --------------------
   // widths and depths
   // --------------------
   localparam int PC_SZ     = 32;                     // address width
   localparam int INSTR_SZ  = 32;                     // RV32I word
   localparam int CL_LEN    = 32;                     // bytes per cache line
   localparam int CL_SZ     = 5;                      // byte offset bits within a line
   localparam int MAX_IPCL  = CL_LEN / 4;             // words per line
   localparam int Q_DEPTH   = 16;                     // power of two so pointers wrap
   localparam int QP_SZ     = 4;                      // queue pointer
   localparam int QC_SZ     = 5;                      // queue count, one bit wider than pointer
   localparam int MAX_RAS   = 8;                      // return stack entries, power of two
   localparam int MR_SZ     = 3;                      // return stack pointer

   localparam logic [PC_SZ-1:0] RESET_VECTOR_ADDR = 32'h0000_0100;

   // system words recognised by the pre-decoder
   localparam logic [INSTR_SZ-1:0] MRET_INSTR   = 32'h3020_0073;
   localparam logic [INSTR_SZ-1:0] ECALL_INSTR  = 32'h0000_0073;
   localparam logic [INSTR_SZ-1:0] EBREAK_INSTR = 32'h0010_0073;

   // --------------------
   // encodings
   // --------------------
   typedef enum logic [2:0] {
      BR_NONE,                                        // falls through to pc+4
      BR_JALR,                                        // guessed as rs1 = x0
      BR_COND,                                        // backward taken, forward not
      BR_JAL,                                         // always taken, pc relative
      BR_RET,                                         // mret, target from return stack
      BR_TRAP                                         // ecall / ebreak, vectors to 0
   } br_kind_t;

   typedef enum logic [1:0] {
      ST_IDLE,                                        // decide next line address
      ST_ACK,                                         // wait for ack of a normal request
      ST_RL_ACK                                       // wait for ack of a redirect request
   } req_state_t;

   // --------------------
   // structs
   // --------------------
   typedef struct packed {
      br_kind_t               kind;
      logic                   is32;                   // standard 32 bit encoding
      logic [INSTR_SZ-1:0]    imm_offset;             // I, B or J immediate, sign extended
      logic                   link_rd;                // rd is x1 or x5
      logic                   link_rs1;               // rs1 is x1 or x5
   } predecode_t;

   typedef struct packed {
      logic [INSTR_SZ-1:0]    instr;
      logic [PC_SZ-1:0]       pc;
      logic [PC_SZ-1:0]       predicted_addr;         // where fetch went after this word
   } fetch_entry_t;

   typedef struct packed {
      logic                   valid;                  // line may be steered into the queue
      logic [PC_SZ-1:0]       pc;                     // requested address, offset selects slot
      logic [CL_LEN*8-1:0]    data;
   } line_t;

endpackage

/* hdl/br_predecode.sv */
// branch pre-decoder for one 32 bit word; instantiated once per cache line slot by the steer stage
`timescale 1ns/1ns

module br_predecode
(
   input  logic [fetch_pkg::INSTR_SZ-1:0] instr,
   output fetch_pkg::predecode_t          info
);

   logic [fetch_pkg::INSTR_SZ-1:0] i_imm, b_imm, j_imm;
   logic [4:0]                     rd, rs1;

   // immediates for jalr, bxx and jal
   assign i_imm = {{21{instr[31]}}, instr[30:20]};
   assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign rd    = instr[11:7];
   assign rs1   = instr[19:15];

   always_comb
   begin
      info            = '0;
      info.kind       = fetch_pkg::BR_NONE;
      info.is32       = (instr[1:0] == 2'b11) && (instr[4:2] != 3'b111);
      info.link_rd    = (rd == 5'd1) || (rd == 5'd5);      // x1 / x5 are link registers
      info.link_rs1   = (rs1 == 5'd1) || (rs1 == 5'd5);
      if (info.is32)
      begin
         case (instr[6:0])
            7'b1100011:                                   // beq .. bgeu
            begin
               info.kind       = fetch_pkg::BR_COND;
               info.imm_offset = b_imm;
            end
            7'b1100111:
            begin
               if (instr[14:12] == 3'b000)                // jalr needs funct3 000
               begin
                  info.kind       = fetch_pkg::BR_JALR;
                  info.imm_offset = i_imm;
               end
            end
            7'b1101111:
            begin
               info.kind       = fetch_pkg::BR_JAL;
               info.imm_offset = j_imm;
            end
            7'b1110011:                                   // system, exact words only
            begin
               if (instr == fetch_pkg::MRET_INSTR)
                  info.kind = fetch_pkg::BR_RET;
               else if ((instr == fetch_pkg::ECALL_INSTR) || (instr == fetch_pkg::EBREAK_INSTR))
                  info.kind = fetch_pkg::BR_TRAP;
            end
            default: info.kind = fetch_pkg::BR_NONE;
         endcase
      end
   end

endmodule

/* hdl/line_request.sv */
// line request stage: owns the fetch PC and the req/ack handshake toward the instruction cache
`timescale 1ns/1ns

module line_request
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          cpu_halt,         // returned lines are dropped
   input  logic                          pc_reload,        // redirect from later stages
   input  logic [fetch_pkg::PC_SZ-1:0]   pc_reload_addr,
   input  logic                          ic_ack,           // one cycle pulse, data valid with it
   input  logic [fetch_pkg::CL_LEN*8-1:0] ic_data,
   output logic                          ic_req,
   output logic [fetch_pkg::PC_SZ-1:0]   ic_addr,
   input  logic                          q_full,
   input  logic [fetch_pkg::PC_SZ-1:0]   next_pc,          // last predicted address from steer
   output fetch_pkg::line_t              line
);

   fetch_pkg::req_state_t          state, nxt_state;
   logic [fetch_pkg::PC_SZ-1:0]    pc, nxt_pc;
   logic                           nxt_req;
   logic                           reload_flag;            // redirect not yet fetched
   logic [fetch_pkg::PC_SZ-1:0]    reload_addr;
   logic [fetch_pkg::PC_SZ-1:0]    lpa;                    // last predicted address
   logic                           xfer;
   logic                           clr_rf;

   assign xfer    = ic_req & ic_ack;
   assign ic_addr = pc;                                    // held while ic_req is high

   // --------------------
   // request FSM
   // --------------------
   always_comb
   begin
      nxt_state = state;
      nxt_req   = ic_req;
      nxt_pc    = pc;
      clr_rf    = 1'b0;
      case (state)
         fetch_pkg::ST_IDLE:
         begin
            // a redirect arriving now goes out directly
            if (pc_reload)
               nxt_pc = pc_reload_addr;
            else if (reload_flag)
               nxt_pc = reload_addr;
            else
               nxt_pc = lpa;
            nxt_req = !q_full;                             // hold off while the queue is full
            if (!q_full)
               nxt_state = (pc_reload | reload_flag) ? fetch_pkg::ST_RL_ACK : fetch_pkg::ST_ACK;
         end
         fetch_pkg::ST_ACK:
         begin
            nxt_req = 1'b1;
            if (xfer)
            begin
               nxt_req   = 1'b0;                           // one idle cycle after every ack
               nxt_state = fetch_pkg::ST_IDLE;
            end
         end
         fetch_pkg::ST_RL_ACK:
         begin
            nxt_req = 1'b1;
            if (xfer)
            begin
               nxt_req   = 1'b0;
               clr_rf    = !pc_reload;                     // a newer redirect keeps the flag
               nxt_state = fetch_pkg::ST_IDLE;
            end
            else if (pc_reload)
               nxt_state = fetch_pkg::ST_ACK;              // this line is stale now
         end
         default: nxt_state = fetch_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         state       <= fetch_pkg::ST_IDLE;
         ic_req      <= 1'b0;
         pc          <= fetch_pkg::RESET_VECTOR_ADDR;
         lpa         <= fetch_pkg::RESET_VECTOR_ADDR;
         reload_flag <= 1'b0;
      end
      else
      begin
         state  <= nxt_state;
         ic_req <= nxt_req;
         pc     <= nxt_pc;
         if (xfer)
            lpa <= next_pc;                                // steer's prediction, or same line
         if (pc_reload)
            reload_flag <= 1'b1;                           // set wins over clear
         else if (clr_rf)
            reload_flag <= 1'b0;
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (pc_reload)
         reload_addr <= pc_reload_addr;
   end

   // line to steer, only when it belongs to the current path
   assign line.valid = xfer & !cpu_halt & !pc_reload &
                       ((state == fetch_pkg::ST_RL_ACK) | !reload_flag);
   assign line.pc    = pc;
   assign line.data  = ic_data;

endmodule

/* hdl/line_steer.sv */
// line steer stage: cuts a returned line into queue writes, predicts next addresses, keeps the RAS
`timescale 1ns/1ns

module line_steer
(
   input  logic                                              clk_in,
   input  logic                                              reset_in,
   input  fetch_pkg::line_t                                  line,
   input  logic [fetch_pkg::QC_SZ-1:0]                       free_cnt,
   output fetch_pkg::fetch_entry_t [fetch_pkg::MAX_IPCL-1:0] wr_entries,
   output logic [fetch_pkg::QC_SZ-1:0]                       wr_count,
   output logic [fetch_pkg::PC_SZ-1:0]                       next_pc
);

   fetch_pkg::predecode_t [fetch_pkg::MAX_IPCL-1:0]             info;
   logic [fetch_pkg::MAX_IPCL-1:0][fetch_pkg::INSTR_SZ-1:0]     word;
   logic [fetch_pkg::MAX_IPCL-1:0][fetch_pkg::PC_SZ-1:0]        slot_pc;

   logic [fetch_pkg::MR_SZ-1:0]                                 ras_ptr, nxt_ptr;
   logic [fetch_pkg::MAX_RAS-1:0][fetch_pkg::PC_SZ-1:0]         ras, nxt_ras;

   logic [fetch_pkg::PC_SZ-1:0]    pred;                   // predicted address of current slot
   logic [fetch_pkg::PC_SZ-1:0]    ret_addr;               // pc+4 of current slot
   logic [4:0]                     rd, rs1;
   logic                           taken;
   logic                           done;

   // --------------------
   // per slot pre-decode
   // --------------------
   for (genvar s = 0; s < fetch_pkg::MAX_IPCL; s++)
   begin : g_slot
      assign word[s]    = line.data[s*fetch_pkg::INSTR_SZ +: fetch_pkg::INSTR_SZ];
      assign slot_pc[s] = {line.pc[fetch_pkg::PC_SZ-1:fetch_pkg::CL_SZ], fetch_pkg::CL_SZ'(s*4)};

      br_predecode u_predecode
      (
         .instr (word[s]),
         .info  (info[s])
      );
   end

   // --------------------
   // walk the line
   // --------------------
   always_comb
   begin
      wr_entries = '0;
      wr_count   = '0;
      next_pc    = line.pc;                                // nothing written, refetch same pc
      nxt_ras    = ras;
      nxt_ptr    = ras_ptr;
      pred       = '0;
      ret_addr   = '0;
      rd         = '0;
      rs1        = '0;
      taken      = 1'b0;
      done       = !line.valid || (free_cnt == '0);
      for (int c = 0; c < fetch_pkg::MAX_IPCL; c++)
      begin
         if (!done && (c >= int'(line.pc[fetch_pkg::CL_SZ-1:2])))   // start at pc offset
         begin
            rd       = word[c][11:7];
            rs1      = word[c][19:15];
            ret_addr = slot_pc[c] + fetch_pkg::PC_SZ'(4);
            pred     = ret_addr;                           // default is sequential
            taken    = 1'b1;
            case (info[c].kind)
               fetch_pkg::BR_COND:
               begin
                  taken = info[c].imm_offset[fetch_pkg::INSTR_SZ-1];   // backward only
                  if (taken)
                     pred = slot_pc[c] + info[c].imm_offset;
               end
               fetch_pkg::BR_JAL:
               begin
                  pred = slot_pc[c] + info[c].imm_offset;
                  if (info[c].link_rd)                     // call, push return address
                  begin
                     nxt_ras[nxt_ptr] = ret_addr;
                     nxt_ptr          = nxt_ptr + 1'b1;
                  end
               end
               fetch_pkg::BR_JALR:
               begin
                  pred = info[c].imm_offset;               // guess rs1 = x0
                  case ({info[c].link_rd, info[c].link_rs1})
                     2'b01: nxt_ptr = nxt_ptr - 1'b1;      // return, pop
                     2'b10:                                // call, push
                     begin
                        nxt_ras[nxt_ptr] = ret_addr;
                        nxt_ptr          = nxt_ptr + 1'b1;
                     end
                     2'b11:                                // pop then push
                     begin
                        if (rs1 != rd)
                           nxt_ptr = nxt_ptr - 1'b1;
                        nxt_ras[nxt_ptr] = ret_addr;
                        nxt_ptr          = nxt_ptr + 1'b1;
                     end
                     default: nxt_ptr = nxt_ptr;
                  endcase
               end
               fetch_pkg::BR_RET:
               begin
                  nxt_ptr = nxt_ptr - 1'b1;
                  pred    = nxt_ras[nxt_ptr];
               end
               fetch_pkg::BR_TRAP: pred = '0;             // trap vector
               default: taken = 1'b0;
            endcase

            wr_entries[wr_count].instr          = word[c];
            wr_entries[wr_count].pc             = slot_pc[c];
            wr_entries[wr_count].predicted_addr = pred;
            wr_count = wr_count + 1'b1;
            next_pc  = pred;
            // stop on a redirect, an odd encoding or a full queue
            done = taken || !info[c].is32 || (wr_count == free_cnt);
         end
      end
   end

   // return stack, pointer wraps
   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         ras_ptr <= '0;
         ras     <= '0;
      end
      else
      begin
         ras_ptr <= nxt_ptr;
         ras     <= nxt_ras;
      end
   end

endmodule

/* hdl/instr_queue.sv */
// instruction queue: circular buffer between steer and decode with a valid/ready output
`timescale 1ns/1ns

module instr_queue
(
   input  logic                                              clk_in,
   input  logic                                              reset_in,
   input  logic                                              flush,     // redirect
   input  fetch_pkg::fetch_entry_t [fetch_pkg::MAX_IPCL-1:0] wr_entries,
   input  logic [fetch_pkg::QC_SZ-1:0]                       wr_count,
   output logic [fetch_pkg::QC_SZ-1:0]                       free_cnt,
   output logic                                              q_full,
   output logic                                              out_valid,
   output fetch_pkg::fetch_entry_t                           out_entry,
   input  logic                                              out_rdy
);

   fetch_pkg::fetch_entry_t         que [fetch_pkg::Q_DEPTH];
   logic [fetch_pkg::QP_SZ-1:0]     qip, qop;               // input / output pointers
   logic [fetch_pkg::QC_SZ-1:0]     qcnt;
   logic                            xfer;                   // entry taken by decode

   assign out_valid = (qcnt != '0);
   assign out_entry = que[qop];                             // held until taken
   assign xfer      = out_valid & out_rdy;
   assign q_full    = (qcnt == fetch_pkg::QC_SZ'(fetch_pkg::Q_DEPTH));
   assign free_cnt  = fetch_pkg::QC_SZ'(fetch_pkg::Q_DEPTH) - qcnt;

   // --------------------
   // storage
   // --------------------
   always_ff @(posedge clk_in)
   begin
      for (int i = 0; i < fetch_pkg::MAX_IPCL; i++)
      begin
         if (i < wr_count)                                  // steer packs writes from slot 0
            que[qip + fetch_pkg::QP_SZ'(i)] <= wr_entries[i];
      end
   end

   // --------------------
   // pointers and count
   // --------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in || flush)
      begin
         qip  <= '0;
         qop  <= '0;
         qcnt <= '0;
      end
      else
      begin
         qip  <= qip + wr_count[fetch_pkg::QP_SZ-1:0];     // at most MAX_IPCL, wraps
         if (xfer)
            qop <= qop + 1'b1;
         qcnt <= qcnt + wr_count - fetch_pkg::QC_SZ'(xfer);
      end
   end

endmodule

/* hdl/fetch_top.sv */
// fetch unit top: line request, line steer and instruction queue wired between cache and decode
`timescale 1ns/1ns

module fetch_top
(
   input  logic                           clk_in,
   input  logic                           reset_in,
   input  logic                           cpu_halt,
   input  logic                           pc_reload,
   input  logic [fetch_pkg::PC_SZ-1:0]    pc_reload_addr,
   // cache port
   output logic                           ic_req,
   output logic [fetch_pkg::PC_SZ-1:0]    ic_addr,
   input  logic                           ic_ack,
   input  logic [fetch_pkg::CL_LEN*8-1:0] ic_data,
   // decode port
   output logic                           out_valid,
   output fetch_pkg::fetch_entry_t        out_entry,
   input  logic                           out_rdy
);

   fetch_pkg::line_t                                  line;       // request -> steer
   logic [fetch_pkg::PC_SZ-1:0]                       next_pc;    // steer -> request
   fetch_pkg::fetch_entry_t [fetch_pkg::MAX_IPCL-1:0] wr_entries; // steer -> queue
   logic [fetch_pkg::QC_SZ-1:0]                       wr_count;
   logic [fetch_pkg::QC_SZ-1:0]                       free_cnt;   // queue -> steer
   logic                                              q_full;     // queue -> request

   line_request u_request
   (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .cpu_halt       (cpu_halt),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .ic_ack         (ic_ack),
      .ic_data        (ic_data),
      .ic_req         (ic_req),
      .ic_addr        (ic_addr),
      .q_full         (q_full),
      .next_pc        (next_pc),
      .line           (line)
   );

   line_steer u_steer
   (
      .clk_in     (clk_in),
      .reset_in   (reset_in),
      .line       (line),
      .free_cnt   (free_cnt),
      .wr_entries (wr_entries),
      .wr_count   (wr_count),
      .next_pc    (next_pc)
   );

   // redirect flushes everything already queued
   instr_queue u_queue
   (
      .clk_in     (clk_in),
      .reset_in   (reset_in),
      .flush      (pc_reload),
      .wr_entries (wr_entries),
      .wr_count   (wr_count),
      .free_cnt   (free_cnt),
      .q_full     (q_full),
      .out_valid  (out_valid),
      .out_entry  (out_entry),
      .out_rdy    (out_rdy)
   );

endmodule

/* bench/fetch_checker.sv */
// reference model of the fetch predictions that compares every decode transfer; instantiated by the testbench
`timescale 1ns/1ns

module fetch_checker
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          cpu_halt,
   input  logic                          pc_reload,
   input  logic [fetch_pkg::PC_SZ-1:0]   pc_reload_addr,
   input  logic                          out_valid,
   input  logic                          out_rdy,
   input  fetch_pkg::fetch_entry_t       out_entry
);

   localparam int PROG_MAX = 16;
   localparam logic [31:0] NOP = 32'h0000_0013;          // addi x0, x0, 0

   logic [31:0] prog_addr [PROG_MAX];
   logic [31:0] prog_data [PROG_MAX];
   int          prog_n;

   logic [31:0] m_pc;                                   // model fetch address
   logic [31:0] m_ras [8];
   logic [2:0]  m_ptr;
   int          err_cnt;                                // read by the testbench
   int          row_xfers;                              // transfers since last redirect
   logic        halt_q;                                 // cpu_halt in the previous cycle
   logic        empty_q;                                // queue was empty in the previous cycle

   // --------------------
   // instruction encoders
   // --------------------
   function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b1100111};
   endfunction

   task automatic put(input logic [31:0] addr, input logic [31:0] data);
      prog_addr[prog_n] = addr;
      prog_data[prog_n] = data;
      prog_n++;
   endtask

   // sparse program where every other address reads as nop
   function automatic logic [31:0] prog_word(input logic [31:0] addr);
      logic [31:0] w;
      w = NOP;
      for (int i = 0; i < prog_n; i++)
         if (prog_addr[i] == addr)
            w = prog_data[i];
      return w;
   endfunction

   initial
   begin
      prog_n = 0;
      // jumps and branches
      put(32'h400, enc_jal(5'd0, 21'h40));                // to 0x440
      put(32'h444, enc_branch(3'b000, 5'd1, 5'd2, 13'h020));    // forward beq
      put(32'h44c, enc_branch(3'b001, 5'd3, 5'd4, 13'h1ff8));   // bne back to 0x444
      // call and return
      put(32'h600, enc_jal(5'd1, 21'h100));               // call 0x700
      put(32'h704, fetch_pkg::MRET_INSTR);
      put(32'h604, enc_jalr(5'd1, 5'd0, 12'h780));        // call 0x780 via jalr
      put(32'h784, fetch_pkg::MRET_INSTR);
      // traps
      put(32'h804, fetch_pkg::ECALL_INSTR);
      put(32'h810, fetch_pkg::EBREAK_INSTR);
   end

   // --------------------
   // reference model
   // --------------------
   always @(posedge clk_in)
   begin
      logic [31:0] instr, pred, imm;
      logic [4:0]  rd, rs1;
      logic        lrd, lrs1;
      if (reset_in)
      begin
         m_pc        = fetch_pkg::RESET_VECTOR_ADDR;
         m_ptr       = '0;
         err_cnt     = 0;
         row_xfers   = 0;
         for (int i = 0; i < 8; i++)
            m_ras[i] = '0;
      end
      else if (pc_reload)
      begin
         m_pc      = pc_reload_addr;                      // queue is flushed at this edge
         row_xfers = 0;
      end
      else if (out_valid && out_rdy)
      begin
         instr = prog_word(m_pc);
         rd    = instr[11:7];
         rs1   = instr[19:15];
         lrd   = (rd == 5'd1) || (rd == 5'd5);
         lrs1  = (rs1 == 5'd1) || (rs1 == 5'd5);
         pred  = m_pc + 32'd4;
         case (instr[6:0])
            7'b1100011:                                   // taken only when backward
            begin
               imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
               if (imm[31])
                  pred = m_pc + imm;
            end
            7'b1101111:
            begin
               imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
               pred = m_pc + imm;
               if (lrd)
               begin
                  m_ras[m_ptr] = m_pc + 32'd4;
                  m_ptr++;
               end
            end
            7'b1100111:
            begin
               if (instr[14:12] == 3'b000)
               begin
                  pred = {{20{instr[31]}}, instr[31:20]};  // target is the immediate
                  if (lrs1 && (!lrd || rs1 != rd))
                     m_ptr--;                             // return part
                  if (lrd)
                  begin
                     m_ras[m_ptr] = m_pc + 32'd4;
                     m_ptr++;
                  end
               end
            end
            7'b1110011:
            begin
               if (instr == fetch_pkg::MRET_INSTR)
               begin
                  m_ptr--;
                  pred = m_ras[m_ptr];
               end
               else if (instr == fetch_pkg::ECALL_INSTR || instr == fetch_pkg::EBREAK_INSTR)
                  pred = '0;
            end
            default: pred = m_pc + 32'd4;
         endcase

         if (out_entry.pc !== m_pc || out_entry.instr !== instr ||
             out_entry.predicted_addr !== pred)
         begin
            $display("[FAIL] %0t ns: entry pc %h instr %h pred %h, expected pc %h instr %h pred %h",
                     $time, out_entry.pc, out_entry.instr, out_entry.predicted_addr,
                     m_pc, instr, pred);
            err_cnt++;
         end
         m_pc = pred;                                     // follow the predicted path
         row_xfers++;
      end
   end

   // an empty queue stays empty across a cycle with cpu_halt high
   always @(posedge clk_in)
   begin
      if (!reset_in && halt_q && empty_q && out_valid)
      begin
         $display("[FAIL] %0t ns: entry enqueued while cpu_halt was high", $time);
         err_cnt++;
      end
      halt_q  = cpu_halt;
      empty_q = !out_valid;
   end

endmodule

/* bench/fetch_props.sv */
// handshake assertions, bound onto the cache request stage and the instruction queue
`timescale 1ns/1ns

module fetch_props
(
   input logic        clk_in,
   input logic        reset_in,
   input logic        abort,                             // flush cancels a pending entry
   input logic        req,
   input logic        ack,
   input logic [95:0] payload
);

   // request or valid holds until accepted
   hold_until_ack: assert property (@(posedge clk_in) disable iff (reset_in || abort)
      req && !ack |=> req)
      else $error("request dropped before it was accepted");

   // payload does not move while waiting
   payload_stable: assert property (@(posedge clk_in) disable iff (reset_in || abort)
      req && !ack |=> $stable(payload))
      else $error("payload changed while waiting for acceptance");

   low_after_reset: assert property (@(posedge clk_in) reset_in |=> !req)
      else $error("handshake active right after reset");

endmodule

bind line_request fetch_props u_req_props
(
   .clk_in   (clk_in),
   .reset_in (reset_in),
   .abort    (1'b0),
   .req      (ic_req),
   .ack      (ic_ack),
   .payload  ({64'b0, ic_addr})
);

bind instr_queue fetch_props u_queue_props
(
   .clk_in   (clk_in),
   .reset_in (reset_in),
   .abort    (flush),
   .req      (out_valid),
   .ack      (out_rdy),
   .payload  (out_entry)
);

/* bench/fetch_tb.sv */
// fetch unit testbench with cache responder, stimulus rows of redirect, ready and halt; simulation top
`timescale 1ns/1ns

module fetch_tb;

   localparam int NROWS = 8;
   localparam int TCLK  = 40;

   typedef struct packed {
      logic        redirect;                             // row starts with a pc_reload
      logic [31:0] start;
      logic [7:0]  count;                                // entries to receive
      logic [7:0]  rdy_pat;                              // out_rdy per cycle, repeats every 8
      logic [7:0]  halt_from;
      logic [7:0]  halt_len;                             // 0 means no halt
   } row_t;

   logic                           clk_in;
   logic                           reset_in;
   logic                           cpu_halt;
   logic                           pc_reload;
   logic [fetch_pkg::PC_SZ-1:0]    pc_reload_addr;
   logic                           ic_req;
   logic [fetch_pkg::PC_SZ-1:0]    ic_addr;
   logic                           ic_ack;
   logic [fetch_pkg::CL_LEN*8-1:0] ic_data;
   logic                           out_valid;
   fetch_pkg::fetch_entry_t        out_entry;
   logic                           out_rdy;

   row_t        rows [NROWS];
   logic [31:0] lcg_state;
   int          entries_seen;

   fetch_top u_dut
   (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .cpu_halt       (cpu_halt),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .ic_req         (ic_req),
      .ic_addr        (ic_addr),
      .ic_ack         (ic_ack),
      .ic_data        (ic_data),
      .out_valid      (out_valid),
      .out_entry      (out_entry),
      .out_rdy        (out_rdy)
   );

   fetch_checker u_chk
   (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .cpu_halt       (cpu_halt),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .out_valid      (out_valid),
      .out_rdy        (out_rdy),
      .out_entry      (out_entry)
   );

   initial
      clk_in = 1'b0;
   always #(TCLK/2) clk_in = ~clk_in;

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // whole aligned line around addr
   function automatic logic [255:0] build_line(input logic [31:0] addr);
      logic [255:0] d;
      for (int s = 0; s < 8; s++)
         d[s*32 +: 32] = u_chk.prog_word({addr[31:5], 5'b0} + 32'(s*4));
      return d;
   endfunction

   // --------------------
   // cache responder
   // --------------------
   initial
   begin
      int delay;
      lcg_state = 32'd23;
      ic_ack    = 1'b0;
      ic_data   = '0;
      forever
      begin
         @(posedge clk_in);
         #2;
         if (!reset_in && ic_req)
         begin
            delay = int'((next_rand() >> 16) % 4) + 1;   // 1 to 4 cycles
            repeat (delay - 1)
            begin
               @(posedge clk_in);
               #2;
            end
            ic_ack  = 1'b1;
            ic_data = build_line(ic_addr);
            @(posedge clk_in);
            #2;
            ic_ack  = 1'b0;
         end
      end
   end

   task automatic apply_row(input int idx);
      row_t r;
      int   err0;
      int   cyc;
      r    = rows[idx];
      err0 = u_chk.err_cnt;
      cyc  = 0;
      if (r.redirect)
      begin
         pc_reload      = 1'b1;
         pc_reload_addr = r.start;
         out_rdy        = 1'b0;
         @(posedge clk_in);
         #2;
         pc_reload = 1'b0;
      end
      while (u_chk.row_xfers < int'(r.count))
      begin
         out_rdy  = r.rdy_pat[cyc % 8];
         cpu_halt = (cyc >= int'(r.halt_from)) && (cyc < int'(r.halt_from) + int'(r.halt_len));
         @(posedge clk_in);
         #2;
         cyc++;
      end
      out_rdy  = 1'b0;
      cpu_halt = 1'b0;
      entries_seen += int'(r.count);
      $display("row %0d from %h: %0d entries in %0d cycles, %0d mismatches",
               idx, r.start, r.count, cyc, u_chk.err_cnt - err0);
   endtask

   // --------------------
   // watchdog
   // --------------------
   initial
   begin
      int total;
      #1;
      total = 0;
      for (int i = 0; i < NROWS; i++)
         total += int'(rows[i].count);
      #(total * 40 * TCLK + 8 * TCLK);
      $display("watchdog expired, fetch stopped delivering entries");
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      //         redirect start   count  ready  halt at / len
      rows[0] = {1'b0, 32'h100, 8'd20, 8'hff, 8'd0, 8'd0};     // straight line from reset
      rows[1] = {1'b1, 32'h400, 8'd10, 8'hff, 8'd0, 8'd0};     // jal, fwd and back branch
      rows[2] = {1'b1, 32'h600, 8'd12, 8'hff, 8'd0, 8'd0};     // call / mret / jalr
      rows[3] = {1'b1, 32'h800, 8'd8,  8'hff, 8'd0, 8'd0};     // ecall to 0
      rows[4] = {1'b1, 32'h810, 8'd6,  8'hb5, 8'd0, 8'd0};     // ebreak to 0
      rows[5] = {1'b1, 32'h400, 8'd24, 8'h01, 8'd0, 8'd0};     // heavy back-pressure
      rows[6] = {1'b1, 32'h600, 8'd12, 8'hff, 8'd3, 8'd20};    // halt mid row
      rows[7] = {1'b1, 32'h100, 8'd12, 8'h0f, 8'd0, 8'd10};    // halt right after redirect
      entries_seen   = 0;
      reset_in       = 1'b1;
      cpu_halt       = 1'b0;
      pc_reload      = 1'b0;
      pc_reload_addr = '0;
      out_rdy        = 1'b0;
      repeat (8) @(posedge clk_in);
      #2;
      reset_in = 1'b0;
      for (int i = 0; i < NROWS; i++)
         apply_row(i);
      $display("%0d rows, %0d entries, %0d errors", NROWS, entries_seen, u_chk.err_cnt);
      if (u_chk.err_cnt == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* fetch_top.f */
hdl/fetch_pkg.sv
hdl/br_predecode.sv
hdl/line_request.sv
hdl/line_steer.sv
hdl/instr_queue.sv
hdl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_props.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/br_predecode.sv
      - hdl/line_request.sv
      - hdl/line_steer.sv
      - hdl/instr_queue.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - bench/fetch_checker.sv
      - bench/fetch_props.sv
      - bench/fetch_tb.sv
